// ==== Makefile ====
obj_dir/VtbCp0: sim.f $(shell cat sim.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tbCp0 -f sim.f

run: obj_dir/VtbCp0
	./obj_dir/VtbCp0 | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== cp0Pkg.sv ====
`default_nettype none

package cp0Pkg;

    // Register numbers, all at select 0
    localparam logic [4:0] regBadVAddr = 5'd8;
    localparam logic [4:0] regCount    = 5'd9;
    localparam logic [4:0] regCompare  = 5'd11;
    localparam logic [4:0] regStatus   = 5'd12;
    localparam logic [4:0] regCause    = 5'd13;
    localparam logic [4:0] regEpc      = 5'd14;
    localparam logic [4:0] regPrId     = 5'd15;
    localparam logic [4:0] regConfig   = 5'd16;

    // Cause.ExcCode, low four bits only
    typedef enum logic [3:0] {
        excInt  = 4'h0,   // Interrupt
        excAdEL = 4'h4,   // Address error on load or fetch
        excAdES = 4'h5,   // Address error on store
        excSys  = 4'h8,   // Syscall
        excBp   = 4'h9,   // Breakpoint
        excRi   = 4'ha,   // Reserved instruction
        excCpU  = 4'hb,   // Coprocessor unusable
        excOv   = 4'hc,   // Integer overflow
        excTr   = 4'hd    // Trap
    } excCode;

    localparam logic [31:0] offsetGeneral  = 32'h0000_0180;
    localparam logic [31:0] offsetSpecial  = 32'h0000_0200;   // Interrupts with Cause.IV set
    localparam logic [31:0] statusWritable = 32'h1240_ff17;   // CU0 RE BEV IM UM ERL EXL IE

    // CP0 instruction as decoded in ID
    typedef struct packed {
        logic        mfc0;
        logic        mtc0;
        logic        eret;
        logic        cop1;
        logic        cop3;
        logic [4:0]  rd;
        logic [2:0]  sel;
        logic [31:0] writeData;   // GPR value for mtc0
    } cp0Request;

    typedef struct packed {
        logic adIf;   // IF
        logic adEl;   // MEM
        logic adEs;   // MEM
        logic ov;     // EX
        logic tr;     // MEM
        logic sys;    // ID
        logic bp;     // ID
        logic ri;     // ID
    } stageFaults;

    typedef struct packed {
        logic [31:0] restartPc;       // Bad fetch address for IF
        logic        isBranchDelay;
    } stageContext;

    typedef struct packed {
        logic ifStage;
        logic idStage;
        logic exStage;
        logic memStage;
    } stageSet;

    // Status at its architectural bit positions
    typedef struct packed {
        logic [2:0] rsvd31;
        logic       cu0;      // 28
        logic [1:0] rsvd27;
        logic       re;       // 25
        logic [1:0] rsvd24;
        logic       bev;      // 22
        logic [5:0] rsvd21;
        logic [7:0] im;       // 15:8
        logic [2:0] rsvd7;
        logic       um;       // 4
        logic       rsvd3;
        logic       erl;      // 2
        logic       exl;      // 1
        logic       ie;       // 0
    } statusFields;

    typedef union packed {
        logic [31:0] raw;     // As moved by mtc0 and mfc0
        statusFields fields;
    } statusWord;

    typedef struct packed {
        logic        taken;
        excCode      code;
        logic        isBranchDelay;
        logic [31:0] restartPc;
    } commitEvent;

endpackage

`default_nettype wire

// ==== cp0Registers.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0Registers #(
    parameter logic [7:0] prIdRevision = 8'h01
) (
    input  wire                  clock,
    input  wire                  reset,
    input  wire cp0Pkg::cp0Request    request,
    input  wire                  idStall,
    input  wire cp0Pkg::commitEvent   commit,
    input  wire cp0Pkg::stageSet      ready,
    input  wire           [31:0] badAddrMem,
    input  wire            [4:0] hwInt,
    input  wire                  idIsFlushed,
    input  wire           [31:0] count,
    input  wire           [31:0] compare,
    input  wire                  timerPending,
    output logic          [31:0] readData,
    output logic                 kernelMode,
    output logic                 reverseEndian,
    output cp0Pkg::statusWord    status,
    output logic                 causeIv,
    output logic          [31:0] epc,
    output logic                 cpUnusable,
    output logic                 interruptRequest,
    output logic                 countWrite,
    output logic                 compareWrite,
    output logic                 countRead,
    output logic          [31:0] writeData
);

    import cp0Pkg::*;

    logic        causeBd;
    logic [1:0]  causeCe;
    logic [4:0]  hwIp;         // IP6:2
    logic [1:0]  swIp;         // IP1:0
    excCode      causeCode;
    logic [31:0] badVAddr;
    logic [7:0]  pending;
    logic [31:0] causeWord;
    logic        accessOk;
    logic        selZero;
    logic        writeOk;      // mtc0 that lands this cycle
    logic        eretGo;

    assign kernelMode    = ~status.fields.um | status.fields.exl | status.fields.erl;
    assign reverseEndian = status.fields.re;
    assign accessOk      = status.fields.cu0 | kernelMode;
    assign selZero       = (request.sel == 3'd0);
    assign writeOk       = accessOk & request.mtc0 & ~idStall & selZero & ~commit.taken;
    assign eretGo        = accessOk & request.eret & ~idStall & ~commit.taken;

    // COP1 and COP3 are always unusable, CP0 needs kernel mode or CU0
    assign cpUnusable = request.cop1 | request.cop3
                      | ((request.mtc0 | request.mfc0 | request.eret) & ~accessOk);

    assign pending   = {timerPending, hwIp, swIp};
    assign causeWord = {causeBd, 1'b0, causeCe, 4'b0, causeIv, 1'b0, 6'b0,
                        pending, 2'b0, causeCode, 2'b0};

    assign interruptRequest = status.fields.ie & (|(pending & status.fields.im))
                            & ~status.fields.exl & ~status.fields.erl & ~idIsFlushed;

    // Timer side
    assign writeData    = request.writeData;
    assign countWrite   = writeOk & (request.rd == regCount);
    assign compareWrite = writeOk & (request.rd == regCompare);
    assign countRead    = accessOk & request.mfc0 & selZero & (request.rd == regCount);

    always_ff @(posedge clock) begin
        if (reset) begin
            status.raw        <= '0;
            status.fields.bev <= 1'b1;   // Boot vectors
            status.fields.erl <= 1'b1;   // Kernel mode out of reset
        end else if (commit.taken) begin
            status.fields.exl <= 1'b1;
        end else if (writeOk && request.rd == regStatus) begin
            status.raw <= request.writeData & statusWritable;   // Reserved bits stay zero
        end else if (eretGo) begin
            if (status.fields.erl)
                status.fields.erl <= 1'b0;
            else
                status.fields.exl <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            causeBd   <= 1'b0;
            causeCe   <= 2'b00;
            causeIv   <= 1'b0;
            hwIp      <= '0;
            swIp      <= '0;
            causeCode <= excInt;
        end else begin
            hwIp <= hwInt;   // Level sampled each cycle
            if (commit.taken) begin
                if (!status.fields.exl)
                    causeBd <= commit.isBranchDelay;   // Keep the first BD when nested
                causeCe   <= request.cop3 ? 2'd3 : (request.cop1 ? 2'd1 : 2'd0);
                causeCode <= commit.code;
            end else if (writeOk && request.rd == regCause) begin
                causeIv <= request.writeData[23];
                swIp    <= request.writeData[9:8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (commit.taken) begin
            if (!status.fields.exl)
                epc <= commit.restartPc;
        end else if (writeOk && request.rd == regEpc) begin
            epc <= request.writeData;
        end
        if (ready.memStage)
            badVAddr <= badAddrMem;
        else if (ready.ifStage)
            badVAddr <= commit.restartPc;   // Bad fetch address
    end

    // mfc0 read mux
    always_comb begin
        readData = '0;
        if (request.mfc0 && accessOk && selZero) begin
            case (request.rd)
                regBadVAddr: readData = badVAddr;
                regCount:    readData = count;
                regCompare:  readData = compare;
                regStatus:   readData = status.raw;
                regCause:    readData = causeWord;
                regEpc:      readData = epc;
                regPrId:     readData = {24'h0, prIdRevision};
                regConfig:   readData = 32'h8000_8000;   // M set, big-endian, K0 zero
                default:     readData = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== cp0Timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0Timer (
    input  wire         clock,
    input  wire         reset,
    input  wire         countWrite,     // mtc0 to Count
    input  wire         compareWrite,   // mtc0 to Compare
    input  wire         countRead,      // Allowed mfc0 of Count
    input  wire  [31:0] writeData,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timerPending    // Cause.IP7
);

    logic match;

    assign match = (count == compare);

    always_ff @(posedge clock) begin
        if (reset) begin
            count        <= '0;
            compare      <= '0;
            timerPending <= 1'b0;
        end else begin
            if (countWrite)
                count <= writeData;
            else if (match)
                count <= '0;              // Wrap on match
            else
                count <= count + 32'd1;

            if (compareWrite)
                compare <= writeData;

            // Sticky until software reads Count
            if (countRead)
                timerPending <= 1'b0;
            else if (match)
                timerPending <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== cp0Top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0Top #(
    parameter logic [31:0] resetVector  = 32'hbfc0_0000,
    parameter logic [31:0] bootBase     = 32'hbfc0_0200,   // BEV set
    parameter logic [31:0] normalBase   = 32'h8000_0000,   // BEV clear
    parameter logic [7:0]  prIdRevision = 8'h01
) (
    input  wire                  clock,
    input  wire                  reset,
    input  wire cp0Pkg::cp0Request    request,
    input  wire                  idStall,
    input  wire                  ifStall,
    input  wire cp0Pkg::stageFaults   faults,
    input  wire cp0Pkg::stageContext  ifCtx,
    input  wire cp0Pkg::stageContext  idCtx,
    input  wire cp0Pkg::stageContext  exCtx,
    input  wire cp0Pkg::stageContext  memCtx,
    input  wire           [31:0] badAddrMem,
    input  wire cp0Pkg::stageSet      canErr,
    input  wire                  idIsFlushed,
    input  wire            [4:0] hwInt,
    output logic          [31:0] readData,
    output logic                 kernelMode,
    output logic                 reverseEndian,
    output cp0Pkg::stageSet      stall,
    output cp0Pkg::stageSet      flush,
    output logic                 excPcSel,
    output logic          [31:0] excPc
);

    import cp0Pkg::*;

    statusWord   status;
    commitEvent  commit;
    stageSet     ready;
    logic        causeIv;
    logic [31:0] epc;
    logic        cpUnusable;
    logic        interruptRequest;
    logic [31:0] count;
    logic [31:0] compare;
    logic        timerPending;
    logic        countWrite;
    logic        compareWrite;
    logic        countRead;
    logic [31:0] writeData;

    exceptionArbiter #(
        .resetVector (resetVector),
        .bootBase    (bootBase),
        .normalBase  (normalBase)
    ) u_exceptionArbiter (
        .clock(clock), .reset(reset), .faults(faults), .cpUnusable(cpUnusable),
        .interruptRequest(interruptRequest), .request(request), .idStall(idStall),
        .ifStall(ifStall), .canErr(canErr), .ifCtx(ifCtx), .idCtx(idCtx), .exCtx(exCtx),
        .memCtx(memCtx), .status(status), .causeIv(causeIv), .epc(epc), .stall(stall),
        .flush(flush), .ready(ready), .commit(commit), .excPcSel(excPcSel), .excPc(excPc)
    );

    cp0Timer u_cp0Timer (
        .clock(clock), .reset(reset), .countWrite(countWrite),
        .compareWrite(compareWrite), .countRead(countRead), .writeData(writeData),
        .count(count), .compare(compare), .timerPending(timerPending)
    );

    cp0Registers #(
        .prIdRevision (prIdRevision)
    ) u_cp0Registers (
        .clock(clock), .reset(reset), .request(request), .idStall(idStall),
        .commit(commit), .ready(ready), .badAddrMem(badAddrMem), .hwInt(hwInt),
        .idIsFlushed(idIsFlushed), .count(count), .compare(compare),
        .timerPending(timerPending), .readData(readData), .kernelMode(kernelMode),
        .reverseEndian(reverseEndian), .status(status), .causeIv(causeIv), .epc(epc),
        .cpUnusable(cpUnusable), .interruptRequest(interruptRequest),
        .countWrite(countWrite), .compareWrite(compareWrite), .countRead(countRead),
        .writeData(writeData)
    );

endmodule

`default_nettype wire

// ==== cp0Top_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0TopAssertions (
    input wire                  clock,
    input wire                  reset,
    input wire cp0Pkg::stageSet flush,
    input wire cp0Pkg::stageSet stall,
    input wire cp0Pkg::stageSet ready
);

    // A flushed stage implies every stage behind it is flushed
    flushOrder: assert property (@(posedge clock) disable iff (reset)
        (!flush.memStage || flush.exStage) && (!flush.exStage || flush.idStage)
        && (!flush.idStage || flush.ifStage))
        else $error("flush is not monotone over the stages");

    // A stage either waits or takes its exception
    stallReady: assert property (@(posedge clock) disable iff (reset)
        (stall & ready) == 4'b0000)
        else $error("stall and ready set for one stage");

    resetStall: assert property (@(posedge clock)
        $fell(reset) |-> stall == 4'b0000)   // First cycle out of reset
        else $error("stall raised right after reset");

endmodule

bind cp0Top cp0TopAssertions u_cp0TopAssertions (
    .clock (clock),
    .reset (reset),
    .flush (flush),
    .stall (stall),
    .ready (ready)
);

`default_nettype wire

// ==== exceptionArbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module exceptionArbiter #(
    parameter logic [31:0] resetVector = 32'hbfc0_0000,
    parameter logic [31:0] bootBase    = 32'hbfc0_0200,
    parameter logic [31:0] normalBase  = 32'h8000_0000
) (
    input  wire                 clock,
    input  wire                 reset,
    input  wire cp0Pkg::stageFaults  faults,
    input  wire                 cpUnusable,
    input  wire                 interruptRequest,
    input  wire cp0Pkg::cp0Request   request,
    input  wire                 idStall,
    input  wire                 ifStall,
    input  wire cp0Pkg::stageSet     canErr,
    input  wire cp0Pkg::stageContext ifCtx,
    input  wire cp0Pkg::stageContext idCtx,
    input  wire cp0Pkg::stageContext exCtx,
    input  wire cp0Pkg::stageContext memCtx,
    input  wire cp0Pkg::statusWord   status,
    input  wire                 causeIv,
    input  wire          [31:0] epc,
    output cp0Pkg::stageSet     stall,
    output cp0Pkg::stageSet     flush,
    output cp0Pkg::stageSet     ready,
    output cp0Pkg::commitEvent  commit,
    output logic                excPcSel,
    output logic         [31:0] excPc
);

    import cp0Pkg::*;

    stageSet     detect;
    stageSet     mask;
    stageSet     ahead;       // Some forward stage is detecting
    logic        idHeld;
    logic        eretGo;
    logic        resetDelay;
    excCode      code;
    stageContext chosen;
    logic [31:0] vectorBase;

    // Flushes IF for the first cycle out of reset
    always_ff @(posedge clock) resetDelay <= reset;

    assign detect.memStage = faults.adEl | faults.adEs | faults.tr;
    assign detect.exStage  = faults.ov;
    assign detect.idStage  = faults.sys | faults.bp | faults.ri | cpUnusable | interruptRequest;
    assign detect.ifStage  = faults.adIf;

    // A stage waits while any stage ahead of it could still fault
    assign mask.memStage = ifStall;
    assign mask.exStage  = ifStall | canErr.memStage;
    assign mask.idStage  = ifStall | canErr.memStage | canErr.exStage;
    assign mask.ifStage  = ifStall | canErr.memStage | canErr.exStage | canErr.idStage;

    assign ahead.memStage = 1'b0;
    assign ahead.exStage  = detect.memStage;
    assign ahead.idStage  = detect.memStage | detect.exStage;
    assign ahead.ifStage  = detect.memStage | detect.exStage | detect.idStage;

    assign idHeld = detect.idStage | request.mtc0 | request.eret;   // CP0 writes wait too
    assign eretGo = request.eret & ~idStall & ~cpUnusable;

    assign stall.memStage = detect.memStage & mask.memStage;
    assign stall.exStage  = detect.exStage & mask.exStage & ~ahead.exStage;
    assign stall.idStage  = idHeld & mask.idStage & ~ahead.idStage;
    assign stall.ifStage  = detect.ifStage & mask.ifStage & ~ahead.ifStage;

    // At most one bit set, the forward-most unmasked fault
    assign ready = detect & ~mask & ~ahead & {4{~idStall}};

    // Detecting stage and all stages behind it
    assign flush.memStage = detect.memStage;
    assign flush.exStage  = flush.memStage | detect.exStage;
    assign flush.idStage  = flush.exStage | detect.idStage;
    assign flush.ifStage  = flush.idStage | detect.ifStage | eretGo | resetDelay;

    // Fixed priority, forward stage first and interrupts last
    always_comb begin
        if (faults.adEl)     code = excAdEL;
        else if (faults.adEs) code = excAdES;
        else if (faults.tr)  code = excTr;
        else if (faults.ov)  code = excOv;
        else if (faults.sys) code = excSys;
        else if (faults.bp)  code = excBp;
        else if (faults.ri)  code = excRi;
        else if (cpUnusable) code = excCpU;
        else if (ready.ifStage) code = excAdEL;   // AdIF is reported as AdEL
        else                 code = excInt;
    end

    always_comb begin
        if (ready.memStage)     chosen = memCtx;
        else if (ready.exStage) chosen = exCtx;
        else if (ready.idStage) chosen = idCtx;
        else                    chosen = ifCtx;
    end

    always_comb begin
        commit.taken         = |ready;
        commit.code          = code;
        commit.isBranchDelay = chosen.isBranchDelay;
        commit.restartPc     = chosen.restartPc;
    end

    assign vectorBase = status.fields.bev ? bootBase : normalBase;

    always_comb begin
        if (reset)
            excPc = resetVector;
        else if (eretGo)
            excPc = status.fields.erl ? resetVector : epc;   // ERL only from reset
        else if (causeIv & interruptRequest & (code == excInt))
            excPc = vectorBase + offsetSpecial;
        else
            excPc = vectorBase + offsetGeneral;
    end

    assign excPcSel = reset | eretGo | (|ready);

endmodule

`default_nettype wire

// ==== sim.f ====
cp0Pkg.sv
cp0Timer.sv
exceptionArbiter.sv
cp0Registers.sv
cp0Top.sv
cp0Top_assertions.sv
tbCp0.sv

// ==== tbCp0.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbCp0;

    import cp0Pkg::*;

    localparam logic [31:0] resetVec   = 32'hbfc0_0000;
    localparam logic [31:0] bootBase   = 32'hbfc0_0200;
    localparam logic [31:0] generalVec = bootBase + 32'h180;   // BEV set
    localparam logic [31:0] specialVec = bootBase + 32'h200;   // Interrupt with IV
    localparam logic [7:0]  revision   = 8'h5a;
    // CU0 RE BEV IM7:0 UM ERL EXL IE
    localparam logic [31:0] writable   = (32'h1 << 28) | (32'h1 << 25) | (32'h1 << 22)
                                       | (32'hff << 8) | (32'h1 << 4) | 32'h7;
    localparam int          timerCompare = 8;

    typedef struct packed {
        cp0Request   req;
        stageFaults  flt;
        stageSet     canErr;
        logic [31:0] memPc;
        logic [31:0] badAddr;
        logic [31:0] expRead;
        logic [31:0] readMask;     // Zero when readData is not checked
        logic        careStall;
        stageSet     expStall;
        logic        careFlush;
        stageSet     expFlush;
        logic        careSel;
        logic        expSel;
        logic        carePc;
        logic [31:0] expPc;
        logic        careKernel;
        logic        expKernel;
        logic        careEndian;
        logic        expEndian;
    } rowT;

    logic        clock;
    logic        reset;
    cp0Request   request;
    logic        idStall;
    logic        ifStall;
    stageFaults  faults;
    stageContext ifCtx;
    stageContext idCtx;
    stageContext exCtx;
    stageContext memCtx;
    logic [31:0] badAddrMem;
    stageSet     canErr;
    logic        idIsFlushed;
    logic [4:0]  hwInt;
    logic [31:0] readData;
    logic        kernelMode;
    logic        reverseEndian;
    stageSet     stall;
    stageSet     flush;
    logic        excPcSel;
    logic [31:0] excPc;

    rowT         rows[$];
    rowT         r;
    logic [15:0] lfsr;
    logic [31:0] epcData;
    logic [31:0] compareData;
    logic [31:0] statusData;
    int          errors;
    int          checks;
    int          waitCycles;

    cp0Top #(
        .resetVector  (resetVec),
        .bootBase     (bootBase),
        .normalBase   (32'h8000_0000),
        .prIdRevision (revision)
    ) u_cp0Top (
        .clock(clock), .reset(reset), .request(request), .idStall(idStall),
        .ifStall(ifStall), .faults(faults), .ifCtx(ifCtx), .idCtx(idCtx), .exCtx(exCtx),
        .memCtx(memCtx), .badAddrMem(badAddrMem), .canErr(canErr),
        .idIsFlushed(idIsFlushed), .hwInt(hwInt), .readData(readData),
        .kernelMode(kernelMode), .reverseEndian(reverseEndian), .stall(stall),
        .flush(flush), .excPcSel(excPcSel), .excPc(excPc)
    );

    always #50 clock = ~clock;

    // Galois LFSR, one step per bit
    task automatic drawWord(output logic [31:0] w);
        logic b;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 16'hb400 : 16'h0000);
            w    = {w[30:0], b};
        end
    endtask

    function automatic rowT idleRow();
        rowT x;
        x            = '0;
        x.careStall  = 1'b1;   // Quiet cycle, no stall, flush or redirect
        x.careFlush  = 1'b1;
        x.careSel    = 1'b1;
        x.careEndian = 1'b1;   // Little-endian unless Status.RE was written
        return x;
    endfunction

    function automatic rowT readRow(input logic [4:0] rd, input logic [31:0] exp,
                                    input logic [31:0] msk);
        rowT x;
        x          = idleRow();
        x.req.mfc0 = 1'b1;
        x.req.rd   = rd;
        x.expRead  = exp;
        x.readMask = msk;
        return x;
    endfunction

    function automatic rowT writeRow(input logic [4:0] rd, input logic [31:0] data);
        rowT x;
        x               = idleRow();
        x.req.mtc0      = 1'b1;
        x.req.rd        = rd;
        x.req.writeData = data;
        return x;
    endfunction

    // Redirect expected with the given flush set and vector
    function automatic rowT redirect(input rowT x, input stageSet fl, input logic [31:0] pc);
        rowT y;
        y          = x;
        y.expSel   = 1'b1;
        y.expFlush = fl;
        y.carePc   = 1'b1;
        y.expPc    = pc;
        return y;
    endfunction

    task automatic applyRow(input rowT x);
        request    <= x.req;
        faults     <= x.flt;
        canErr     <= x.canErr;
        memCtx     <= {x.memPc, 1'b0};
        badAddrMem <= x.badAddr;
    endtask

    task automatic checkRow(input int n, input rowT x);
        checks++;
        if (((readData ^ x.expRead) & x.readMask) != 32'h0) begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d readData %h expected %h mask %h",
                     $time, n, readData, x.expRead, x.readMask);
        end
        if (x.careStall && stall != x.expStall) begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d stall %b expected %b",
                     $time, n, stall, x.expStall);
        end
        if (x.careFlush && flush != x.expFlush) begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d flush %b expected %b",
                     $time, n, flush, x.expFlush);
        end
        if (x.careSel && excPcSel != x.expSel) begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d excPcSel %b expected %b",
                     $time, n, excPcSel, x.expSel);
        end
        if (x.carePc && excPc != x.expPc) begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d excPc %h expected %h",
                     $time, n, excPc, x.expPc);
        end
        if (x.careKernel && kernelMode != x.expKernel) begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d kernelMode %b expected %b",
                     $time, n, kernelMode, x.expKernel);
        end
        if (x.careEndian && reverseEndian != x.expEndian) begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d reverseEndian %b expected %b",
                     $time, n, reverseEndian, x.expEndian);
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        request = '0;
        idStall = 1'b0;
        ifStall = 1'b0;
        faults = '0;
        ifCtx = '0;
        idCtx = {32'h8000_0400, 1'b0};
        exCtx = '0;
        memCtx = '0;
        badAddrMem = '0;
        canErr = '0;
        idIsFlushed = 1'b0;
        hwInt = '0;
        lfsr = 16'd48489;
        errors = 0;
        checks = 0;

        drawWord(epcData);
        drawWord(compareData);
        drawWord(statusData);
        statusData = statusData | 32'h0200_0004;   // Keep ERL for kernel mode, RE on

        // Reset values and software round trips
        r = readRow(regStatus, 32'h0040_0004, 32'hffff_ffff);
        r.careKernel = 1'b1;
        r.expKernel  = 1'b1;
        rows.push_back(r);
        rows.push_back(readRow(regPrId, {24'h0, revision}, 32'hffff_ffff));
        rows.push_back(readRow(regConfig, 32'h8000_8000, 32'hffff_ffff));
        rows.push_back(writeRow(regEpc, epcData));
        rows.push_back(readRow(regEpc, epcData, 32'hffff_ffff));
        rows.push_back(writeRow(regCompare, compareData));
        rows.push_back(readRow(regCompare, compareData, 32'hffff_ffff));
        rows.push_back(writeRow(regStatus, statusData));
        r = readRow(regStatus, statusData & writable, 32'hffff_ffff);
        r.expEndian = 1'b1;
        rows.push_back(r);
        r = writeRow(regStatus, 32'h0040_0000);   // BEV only
        r.expEndian = 1'b1;
        rows.push_back(r);

        // MEM AdES against ID Sys, MEM wins
        r = idleRow();
        r.flt.adEs = 1'b1;
        r.flt.sys = 1'b1;
        r.memPc = 32'h8000_1000;
        r.badAddr = 32'h1234_5678;
        rows.push_back(redirect(r, 4'b1111, generalVec));
        rows.push_back(readRow(regEpc, 32'h8000_1000, 32'hffff_ffff));
        rows.push_back(readRow(regBadVAddr, 32'h1234_5678, 32'hffff_ffff));
        rows.push_back(readRow(regCause, 32'd5 << 2, 32'h7c));

        // ID RI held by MEM canErr, then taken
        rows.push_back(writeRow(regStatus, 32'h0040_0000));   // EXL clear, EPC is live
        r = idleRow();
        r.flt.ri = 1'b1;
        r.canErr.memStage = 1'b1;
        r.expStall = 4'b0100;
        r.expFlush = 4'b1100;   // Detecting stage and IF behind it
        rows.push_back(r);
        r = readRow(regEpc, 32'h8000_1000, 32'hffff_ffff);   // Untouched by the held cycle
        r.flt.ri = 1'b1;
        rows.push_back(redirect(r, 4'b1100, generalVec));
        rows.push_back(readRow(regEpc, 32'h8000_0400, 32'hffff_ffff));   // ID restart PC
        rows.push_back(readRow(regCause, 32'd10 << 2, 32'h7c));

        // ERET back through EPC
        rows.push_back(writeRow(regEpc, 32'h8000_2000));
        r = idleRow();
        r.req.eret = 1'b1;
        rows.push_back(redirect(r, 4'b1000, 32'h8000_2000));
        rows.push_back(readRow(regStatus, 32'h0040_0000, 32'hffff_ffff));
        rows.push_back(writeRow(regStatus, 32'h0040_0012));   // UM with EXL
        rows.push_back(redirect(r, 4'b1000, 32'h8000_2000));
        r = redirect(writeRow(regCompare, 32'h0), 4'b1100, generalVec);   // User mode mtc0
        r.careKernel = 1'b1;
        rows.push_back(r);
        r = readRow(regCause, 32'd11 << 2, 32'h7c);
        r.careKernel = 1'b1;
        r.expKernel  = 1'b1;
        rows.push_back(r);

        // Timer interrupt through the IV vector
        rows.push_back(writeRow(regStatus, 32'h0040_8000));   // BEV IM7
        rows.push_back(writeRow(regCause, 32'h0080_0000));    // IV
        rows.push_back(writeRow(regCount, 32'h0));
        rows.push_back(writeRow(regCompare, timerCompare));
        rows.push_back(readRow(regCount, 32'd1, 32'hffff_ffff));   // Also drops IP7
        rows.push_back(writeRow(regStatus, 32'h0040_8001));        // IE
        // Count reads 3 up to Compare here, the match edge sets IP7
        for (int k = 3; k <= timerCompare; k++)
            rows.push_back(idleRow());
        rows.push_back(redirect(idleRow(), 4'b1100, specialVec));
        rows.push_back(readRow(regCause, 32'h0000_8000, 32'h0000_807c));
        rows.push_back(readRow(regCount, 32'd2, 32'hffff_ffff));
        rows.push_back(readRow(regCause, 32'h0, 32'h0000_8000));

        for (int c = 0; c < 15; c++)
            @(posedge clock);
        // Reset redirect, sampled mid-cycle
        @(negedge clock);
        checks++;
        if (!excPcSel || excPc != resetVec) begin
            errors++;
            $display("CHECK FAILED at %0t: reset vector %h sel %b", $time, excPc, excPcSel);
        end
        @(posedge clock);
        reset <= 1'b0;   // Sixteenth edge in reset

        waitCycles = 0;
        @(negedge clock);
        while (flush.ifStage) begin
            waitCycles++;
            if (waitCycles > 10) begin
                $display("IF flush never dropped after reset");
                $display("Simulation failed");
                $finish;
            end
            @(negedge clock);
        end

        for (int n = 0; n < rows.size(); n++) begin
            @(posedge clock);
            applyRow(rows[n]);
            @(negedge clock);
            checkRow(n, rows[n]);
        end
        @(posedge clock);
        applyRow(idleRow());
        @(posedge clock);

        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
